// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= rename_unit_tb
FILE_LIST ?= rename_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := tests failed
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rename_unit.f
src/rename_arch_pkg.sv
src/rename_types_pkg.sv
src/rename_control.sv
src/free_list.sv
src/spec_rat.sv
src/arch_rat.sv
src/rename_unit.sv
sim/rename_unit_assert.sv
sim/rename_unit_tb.sv

// File: sim/rename_unit_assert.sv
`timescale 1ns/10ps

module rename_unit_assert (
    input logic                         clock,
    input logic                         reset_n,
    input logic                         flush,
    input logic                         rename_ready,
    input rename_arch_pkg::free_count_t free_count
);

    import rename_arch_pkg::*;

    free_count_bound: assert property (
        @(posedge clock) disable iff (reset_n)
        free_count <= free_count_t'(free_depth)
    ) else $error("free count above free list depth");

    // Flush rewinds every speculative allocation
    flush_rewinds_free_list: assert property (
        @(posedge clock) disable iff (reset_n)
        flush |=> free_count == free_count_t'(free_depth)
    ) else $error("free list not full after flush");

    // A stalled cycle allocates nothing
    no_alloc_when_stalled: assert property (
        @(posedge clock) disable iff (reset_n)
        !rename_ready |=> free_count >= $past(free_count)
    ) else $error("free count fell after a stalled cycle");

endmodule

bind rename_unit rename_unit_assert u_assert (
    .clock        (clock),
    .reset_n      (reset_n),
    .flush        (flush),
    .rename_ready (rename_ready),
    .free_count   (free_count)
);

// File: sim/rename_unit_tb.sv
`timescale 1ns/10ps

module rename_unit_tb;

    import rename_arch_pkg::*;
    import rename_types_pkg::*;

    localparam int clock_period = 20;
    localparam int reset_cycles = 4;
    localparam int num_cycles   = 3000;

    logic        clock;
    logic        reset_n;
    logic        flush;
    logic        rename_ready;
    rename_req_t rename_req [2];
    commit_t     commit [2];
    rename_res_t rename_res [2];
    preg_t       debug_map [num_lregs];

    // Reference model
    preg_t   model_spec [num_lregs];
    preg_t   model_arch [num_lregs];
    preg_t   free_q [$];
    int      spec_alloc;
    commit_t rob_q [$];

    integer seed;
    int     error_count;
    int     check_count;
    int     cycle;
    logic   hold_req;

    rename_unit dut (
        .clock        (clock),
        .reset_n      (reset_n),
        .rename_req   (rename_req),
        .commit       (commit),
        .flush        (flush),
        .rename_ready (rename_ready),
        .rename_res   (rename_res),
        .debug_map    (debug_map)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(clock_period / 2) clock = ~clock;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic model_reset();
        free_q.delete();
        rob_q.delete();
        for (int i = 0; i < num_lregs; i++) begin
            model_spec[i] = preg_t'(i);
            model_arch[i] = preg_t'(i);
        end
        for (int i = 0; i < free_depth; i++) begin
            free_q.push_back(preg_t'(free_depth + i));
        end
        spec_alloc = 0;
    endtask

    function automatic rename_req_t make_req(input logic [31:0] r);
        rename_req_t req;
        req.valid    = r[0] | r[1];
        req.has_dest = r[2] | r[3];
        req.src1     = r[8:4];
        req.src2     = r[13:9];
        req.dest     = r[18:14];
        return req;
    endfunction

    task automatic drive_inputs();
        logic [31:0] r_ctl;
        logic [31:0] r_req0;
        logic [31:0] r_req1;
        logic [31:0] r_dep;
        int          n_commit;
        r_ctl  = $random(seed);
        r_req0 = $random(seed);
        r_req1 = $random(seed);
        r_dep  = $random(seed);
        flush  = (r_ctl % 32'd40) == 32'd0;
        // Slow retirement phases let the free list run dry
        if ((cycle / 150) % 2 == 1) begin
            n_commit = (r_ctl[9:7] == 3'd0) ? 1 : 0;
        end else begin
            n_commit = int'(r_ctl[11:10]) % 3;
        end
        if (n_commit > rob_q.size()) begin
            n_commit = rob_q.size();
        end
        for (int p = 0; p < 2; p++) begin
            if (p < n_commit) begin
                commit[p] = rob_q[p];
            end else begin
                commit[p] = '0;
            end
        end
        // Stalled requests are held by the source
        if (!hold_req) begin
            rename_req[0] = make_req(r_req0);
            rename_req[1] = make_req(r_req1);
            if (r_dep[1:0] == 2'd0) begin
                rename_req[1].src1 = rename_req[0].dest;
            end
            if (r_dep[3:2] == 2'd0) begin
                rename_req[1].src2 = rename_req[0].dest;
            end
            if (r_dep[5:4] == 2'd0) begin
                rename_req[1].dest = rename_req[0].dest;
            end
        end
    endtask

    task automatic check_cycle();
        int          demand;
        int          free_now;
        int          taken;
        logic        exp_ready;
        logic        slot0_writes;
        preg_t       exp_pdest [2];
        preg_t       exp_old [2];
        preg_t       exp_psrc1;
        preg_t       exp_psrc2;
        rename_req_t req;
        commit_t     entry;

        // Commits of earlier edges only
        for (int i = 0; i < num_lregs; i++) begin
            check_value($sformatf("debug_map[%0d] cycle %0d", i, cycle),
                        int'(model_arch[i]), int'(debug_map[i]));
        end

        demand = 0;
        for (int s = 0; s < 2; s++) begin
            if (rename_req[s].valid && rename_req[s].has_dest) begin
                demand++;
            end
        end
        free_now  = free_depth - spec_alloc;
        exp_ready = (free_now >= demand) && !flush;
        check_value($sformatf("free_count cycle %0d", cycle), free_now, int'(dut.free_count));
        check_value($sformatf("rename_ready cycle %0d", cycle), int'(exp_ready),
                    int'(rename_ready));
        if (!rename_ready && dut.alloc_grant != 2'b00) begin
            error_count++;
            $display("allocation granted while rename_ready is low, cycle %0d", cycle);
        end

        if (exp_ready) begin
            taken        = 0;
            slot0_writes = rename_req[0].valid && rename_req[0].has_dest;
            for (int s = 0; s < 2; s++) begin
                req = rename_req[s];
                if (req.valid) begin
                    exp_psrc1  = model_spec[req.src1];
                    exp_psrc2  = model_spec[req.src2];
                    exp_old[s] = model_spec[req.dest];
                    // In-group producer overrides the table
                    if (s == 1 && slot0_writes) begin
                        if (req.src1 == rename_req[0].dest) begin
                            exp_psrc1 = exp_pdest[0];
                        end
                        if (req.src2 == rename_req[0].dest) begin
                            exp_psrc2 = exp_pdest[0];
                        end
                        if (req.dest == rename_req[0].dest) begin
                            exp_old[s] = exp_pdest[0];
                        end
                    end
                    check_value($sformatf("psrc1 slot %0d cycle %0d", s, cycle),
                                int'(exp_psrc1), int'(rename_res[s].psrc1));
                    check_value($sformatf("psrc2 slot %0d cycle %0d", s, cycle),
                                int'(exp_psrc2), int'(rename_res[s].psrc2));
                    entry          = '0;
                    entry.valid    = 1'b1;
                    entry.has_dest = req.has_dest;
                    entry.lreg     = req.dest;
                    if (req.has_dest) begin
                        exp_pdest[s] = free_q[spec_alloc + taken];
                        taken++;
                        check_value($sformatf("pdest slot %0d cycle %0d", s, cycle),
                                    int'(exp_pdest[s]), int'(rename_res[s].pdest));
                        check_value($sformatf("old_pdest slot %0d cycle %0d", s, cycle),
                                    int'(exp_old[s]), int'(rename_res[s].old_pdest));
                        entry.preg     = exp_pdest[s];
                        entry.old_preg = exp_old[s];
                    end
                    rob_q.push_back(entry);
                end
            end
            // Younger slot written last
            for (int s = 0; s < 2; s++) begin
                if (rename_req[s].valid && rename_req[s].has_dest) begin
                    model_spec[rename_req[s].dest] = exp_pdest[s];
                end
            end
            spec_alloc = spec_alloc + taken;
        end
        hold_req = !exp_ready && (rename_req[0].valid || rename_req[1].valid);

        for (int p = 0; p < 2; p++) begin
            if (commit[p].valid) begin
                entry = rob_q.pop_front();
                if (entry.has_dest) begin
                    model_arch[entry.lreg] = entry.preg;
                    free_q.delete(0);
                    free_q.push_back(entry.old_preg);
                    spec_alloc--;
                end
            end
        end

        if (flush) begin
            rob_q.delete();
            spec_alloc = 0;
            model_spec = model_arch;
        end
    endtask

    initial begin
        seed        = 32'hc9c0;
        error_count = 0;
        check_count = 0;
        cycle       = 0;
        hold_req    = 1'b0;
        reset_n     = 1'b1;
        flush       = 1'b0;
        for (int s = 0; s < 2; s++) begin
            rename_req[s] = '0;
            commit[s]     = '0;
        end
        model_reset();
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset_n = 1'b0;
        for (cycle = 0; cycle < num_cycles; cycle++) begin
            @(posedge clock);
            #1;
            drive_inputs();
            #9;
            check_cycle();
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #((reset_cycles + num_cycles + 50) * clock_period);
        $display("timeout: simulation did not reach the end of the test loop");
        $display("tests failed");
        $finish;
    end

endmodule

// File: src/arch_rat.sv
`timescale 1ns/10ps

module arch_rat (
    input  logic                      clock,
    input  logic                      reset_n,
    input  rename_types_pkg::commit_t commit [2],
    input  logic [1:0]                free_push,
    output rename_arch_pkg::preg_t    arch_next [rename_arch_pkg::num_lregs],
    output rename_arch_pkg::preg_t    debug_map [rename_arch_pkg::num_lregs]
);

    import rename_arch_pkg::*;

    preg_t arch_map [num_lregs];

    // Port 1 is younger, so it overrides port 0 on the same lreg
    always_comb begin
        arch_next = arch_map;
        for (int p = 0; p < 2; p++) begin
            if (free_push[p]) begin
                arch_next[commit[p].lreg] = commit[p].preg;
            end
        end
    end

    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            for (int i = 0; i < num_lregs; i++) begin
                arch_map[i] <= preg_t'(i);
            end
        end else begin
            arch_map <= arch_next;
        end
    end

    assign debug_map = arch_map;

endmodule

// File: src/free_list.sv
`timescale 1ns/10ps

module free_list (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic [1:0]                   alloc_grant,
    input  logic [1:0]                   free_push,
    input  rename_types_pkg::commit_t    commit [2],
    input  logic                         restore,
    output rename_arch_pkg::preg_t       alloc_preg [2],
    output rename_arch_pkg::free_count_t free_count
);

    import rename_arch_pkg::*;

    localparam int idx_width = $clog2(free_depth);

    // Extra wrap bit so that tail - head spans 0 to free_depth
    typedef logic [idx_width:0] ptr_t;

    preg_t mem [free_depth];

    ptr_t       spec_head;
    ptr_t       commit_head;
    ptr_t       tail;
    ptr_t       head_next;
    ptr_t       tail_second;
    ptr_t       commit_head_next;
    logic [1:0] grant_count;
    logic [1:0] push_count;

    assign grant_count = 2'(alloc_grant[0]) + 2'(alloc_grant[1]);
    assign push_count  = 2'(free_push[0]) + 2'(free_push[1]);

    assign head_next = spec_head + ptr_t'(1);

    // Slot 1 skips the entry that slot 0 takes
    assign alloc_preg[0] = mem[spec_head[idx_width-1:0]];
    assign alloc_preg[1] = alloc_grant[0] ? mem[head_next[idx_width-1:0]]
                                          : mem[spec_head[idx_width-1:0]];

    // Port 1 pushes behind port 0 when both retire a dest
    assign tail_second = free_push[0] ? tail + ptr_t'(1) : tail;

    assign commit_head_next = commit_head + ptr_t'(push_count);

    assign free_count = free_count_t'(tail - spec_head);

    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            spec_head   <= '0;
            commit_head <= '0;
            tail        <= ptr_t'(free_depth);
            for (int i = 0; i < free_depth; i++) begin
                mem[i] <= preg_t'(free_depth + i);
            end
        end else begin
            if (free_push[0]) begin
                mem[tail[idx_width-1:0]] <= commit[0].old_preg;
            end
            if (free_push[1]) begin
                mem[tail_second[idx_width-1:0]] <= commit[1].old_preg;
            end
            tail        <= tail + ptr_t'(push_count);
            commit_head <= commit_head_next;

            // Drop every speculative allocation past the last commit
            if (restore) begin
                spec_head <= commit_head_next;
            end else begin
                spec_head <= spec_head + ptr_t'(grant_count);
            end
        end
    end

endmodule

// File: src/rename_arch_pkg.sv
package rename_arch_pkg;

    // Register file geometry
    localparam int num_lregs  = 32;
    localparam int num_pregs  = 64;
    localparam int lreg_width = $clog2(num_lregs);
    localparam int preg_width = $clog2(num_pregs);

    // Pregs left unmapped once both tables hold the identity map
    localparam int free_depth = num_pregs - num_lregs;

    // Logical register index
    typedef logic [lreg_width-1:0] lreg_t;

    // Physical register index
    typedef logic [preg_width-1:0] preg_t;

    // Free entry count, 0 up to free_depth inclusive
    typedef logic [$clog2(free_depth):0] free_count_t;

endpackage

// File: src/rename_control.sv
`timescale 1ns/10ps

module rename_control (
    input  logic                          clock,
    input  logic                          reset_n,
    input  rename_types_pkg::rename_req_t rename_req [2],
    input  rename_types_pkg::commit_t     commit [2],
    input  logic                          flush,
    input  rename_arch_pkg::free_count_t  free_count,
    output logic                          rename_ready,
    output logic [1:0]                    alloc_grant,
    output logic [1:0]                    free_push,
    output logic                          restore
);

    logic [1:0] wants_dest;
    logic [1:0] demand;
    logic       enough_free;
    logic       flush_pending;

    // Reset counts as a flush that lands on the first edge after it
    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            flush_pending <= 1'b1;
        end else begin
            flush_pending <= 1'b0;
        end
    end

    assign wants_dest[0] = rename_req[0].valid && rename_req[0].has_dest;
    assign wants_dest[1] = rename_req[1].valid && rename_req[1].has_dest;

    assign demand      = 2'(wants_dest[0]) + 2'(wants_dest[1]);
    assign enough_free = free_count >= 6'(demand);

    // All or nothing: a short free list stalls both slots
    assign rename_ready = enough_free && !flush && !flush_pending;

    assign alloc_grant[0] = rename_ready && wants_dest[0];
    assign alloc_grant[1] = rename_ready && wants_dest[1];

    // Commits never stall
    assign free_push[0] = commit[0].valid && commit[0].has_dest;
    assign free_push[1] = commit[1].valid && commit[1].has_dest;

    assign restore = flush || flush_pending;

endmodule

// File: src/rename_types_pkg.sv
package rename_types_pkg;

    // One decoded instruction offered for rename
    typedef struct packed {
        logic                   valid;
        logic                   has_dest;
        rename_arch_pkg::lreg_t src1;
        rename_arch_pkg::lreg_t src2;
        rename_arch_pkg::lreg_t dest;
    } rename_req_t;

    // Result of renaming one slot
    typedef struct packed {
        rename_arch_pkg::preg_t psrc1;
        rename_arch_pkg::preg_t psrc2;
        rename_arch_pkg::preg_t pdest;
        // Prior mapping of dest, freed when this instruction retires
        rename_arch_pkg::preg_t old_pdest;
    } rename_res_t;

    // One retiring instruction, oldest in port 0
    typedef struct packed {
        logic                   valid;
        logic                   has_dest;
        rename_arch_pkg::lreg_t lreg;
        rename_arch_pkg::preg_t preg;
        rename_arch_pkg::preg_t old_preg;
    } commit_t;

endpackage

// File: src/rename_unit.sv
`timescale 1ns/10ps

module rename_unit (
    input  logic                          clock,
    input  logic                          reset_n,
    input  rename_types_pkg::rename_req_t rename_req [2],
    input  rename_types_pkg::commit_t     commit [2],
    input  logic                          flush,
    output logic                          rename_ready,
    output rename_types_pkg::rename_res_t rename_res [2],
    output rename_arch_pkg::preg_t        debug_map [rename_arch_pkg::num_lregs]
);

    import rename_arch_pkg::*;

    logic [1:0]  alloc_grant;
    logic [1:0]  free_push;
    logic        restore;
    free_count_t free_count;
    preg_t       alloc_preg [2];
    preg_t       arch_next [num_lregs];

    rename_control u_control (
        .clock        (clock),
        .reset_n      (reset_n),
        .rename_req   (rename_req),
        .commit       (commit),
        .flush        (flush),
        .free_count   (free_count),
        .rename_ready (rename_ready),
        .alloc_grant  (alloc_grant),
        .free_push    (free_push),
        .restore      (restore)
    );

    free_list u_free_list (
        .clock       (clock),
        .reset_n     (reset_n),
        .alloc_grant (alloc_grant),
        .free_push   (free_push),
        .commit      (commit),
        .restore     (restore),
        .alloc_preg  (alloc_preg),
        .free_count  (free_count)
    );

    // Speculative map restores from the committed map's next state
    spec_rat u_spec_rat (
        .clock       (clock),
        .reset_n     (reset_n),
        .rename_req  (rename_req),
        .alloc_grant (alloc_grant),
        .alloc_preg  (alloc_preg),
        .restore     (restore),
        .arch_next   (arch_next),
        .rename_res  (rename_res)
    );

    arch_rat u_arch_rat (
        .clock     (clock),
        .reset_n   (reset_n),
        .commit    (commit),
        .free_push (free_push),
        .arch_next (arch_next),
        .debug_map (debug_map)
    );

endmodule

// File: src/spec_rat.sv
`timescale 1ns/10ps

module spec_rat (
    input  logic                          clock,
    input  logic                          reset_n,
    input  rename_types_pkg::rename_req_t rename_req [2],
    input  logic [1:0]                    alloc_grant,
    input  rename_arch_pkg::preg_t        alloc_preg [2],
    input  logic                          restore,
    input  rename_arch_pkg::preg_t        arch_next [rename_arch_pkg::num_lregs],
    output rename_types_pkg::rename_res_t rename_res [2]
);

    import rename_arch_pkg::*;

    preg_t spec_map [num_lregs];

    lreg_t dest0;
    logic  hit_src1;
    logic  hit_src2;
    logic  hit_dest;

    assign dest0 = rename_req[0].dest;

    // Slot 1 operands produced by slot 0 of the same group
    assign hit_src1 = alloc_grant[0] && (rename_req[1].src1 == dest0);
    assign hit_src2 = alloc_grant[0] && (rename_req[1].src2 == dest0);
    assign hit_dest = alloc_grant[0] && (rename_req[1].dest == dest0);

    always_comb begin
        rename_res[0].psrc1     = spec_map[rename_req[0].src1];
        rename_res[0].psrc2     = spec_map[rename_req[0].src2];
        rename_res[0].pdest     = alloc_preg[0];
        rename_res[0].old_pdest = spec_map[dest0];

        rename_res[1].psrc1     = hit_src1 ? alloc_preg[0] : spec_map[rename_req[1].src1];
        rename_res[1].psrc2     = hit_src2 ? alloc_preg[0] : spec_map[rename_req[1].src2];
        rename_res[1].pdest     = alloc_preg[1];
        rename_res[1].old_pdest = hit_dest ? alloc_preg[0] : spec_map[rename_req[1].dest];
    end

    always_ff @(posedge clock or posedge reset_n) begin
        if (reset_n) begin
            for (int i = 0; i < num_lregs; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (restore) begin
            // Committed state including this edge's retirements
            spec_map <= arch_next;
        end else begin
            if (alloc_grant[0]) begin
                spec_map[dest0] <= alloc_preg[0];
            end
            // Younger slot lands last on a shared dest
            if (alloc_grant[1]) begin
                spec_map[rename_req[1].dest] <= alloc_preg[1];
            end
        end
    end

endmodule
